// File: source/bitmap_pkg.sv
package bitmap_pkg;

    // Bits per pixel of the bitmap
    typedef enum logic [1:0] {
        cm_2bpp,
        cm_4bpp,
        cm_8bpp,
        cm_16bpp
    } color_mode_e;

    // Image width in pixels
    typedef enum logic [1:0] {
        iw_256,
        iw_512,
        iw_1024,
        iw_2048
    } image_width_e;

    // Vertical wrap of the image
    typedef enum logic [1:0] {
        rl_256,
        rl_512,
        rl_none
    } row_limit_e;

    // Meaning of an 8-bit pixel
    typedef enum logic {
        pm_palette,
        pm_direct
    } palette_mode_e;

    localparam int VRAM_ADDR_W  = 19;                    // 512 KB video memory
    localparam int WORD_W       = 32;
    localparam int PIXEL_W      = 16;
    localparam int GROUP_PIXELS = 16;
    localparam int BANK_WORDS   = 8;                     // 16 pixels at 16 bpp
    localparam int BANK_ADDR_W  = $clog2(BANK_WORDS);

    // Memory words holding one 16-pixel group
    function automatic logic [3:0] words_per_group(input color_mode_e mode);
        case (mode)
            cm_2bpp:  return 4'd1;
            cm_4bpp:  return 4'd2;
            cm_8bpp:  return 4'd4;
            default:  return 4'd8;
        endcase
    endfunction

endpackage

// File: source/bitmap_if.sv
// Word writes from the fetch stage into the line buffer
interface line_write_if;
    logic                                bank;
    logic [bitmap_pkg::BANK_ADDR_W-1:0]  word;
    logic [bitmap_pkg::WORD_W-1:0]       data;
    logic                                strobe;    // One word per cycle when high

    modport writer (output bank, word, data, strobe);
    modport buffer (input bank, word, data, strobe);
endinterface

// Bank ownership between fetch and unpack, plus the buffer read port
interface bank_handoff_if;
    logic                                filled;       // Pulse
    logic                                filled_bank;
    logic                                freed;        // Pulse
    logic                                freed_bank;
    logic                                rd_bank;
    logic [bitmap_pkg::BANK_ADDR_W-1:0]  rd_word;
    logic [bitmap_pkg::WORD_W-1:0]       rd_data;      // One cycle after rd_bank/rd_word

    modport producer (
        output filled, filled_bank,
        input  freed, freed_bank
    );

    modport consumer (
        input  filled, filled_bank, rd_data,
        output freed, freed_bank, rd_bank, rd_word
    );

    modport storage (
        input  rd_bank, rd_word,
        output rd_data
    );
endinterface

// File: source/bitmap_fetch.sv
module bitmap_fetch #(
    parameter int ADDR_W = bitmap_pkg::VRAM_ADDR_W
) (
    input  logic                          CLK,
    input  logic                          RESET_n,
    input  bitmap_pkg::color_mode_e       color_mode,
    input  bitmap_pkg::image_width_e      image_width,
    input  bitmap_pkg::row_limit_e        row_limit,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic [10:0]                   req_x,
    input  logic [12:0]                   req_y,
    output logic [ADDR_W-1:0]             araddr,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [bitmap_pkg::WORD_W-1:0] rdata,
    input  logic                          rvalid,
    output logic                          rready,
    line_write_if.writer                  lw,
    bank_handoff_if.producer              bh
);
    localparam int LIN_W = 25;  // 13-bit y shifted by 11, times 2 for 16 bpp

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } state_e;

    state_e                             state;
    logic [bitmap_pkg::BANK_ADDR_W-1:0] word_idx;
    logic                               fill_ptr;     // Next bank to fill
    logic [1:0]                         bank_full;
    logic [12:0]                        y_eff;
    logic [10:0]                        x_eff;
    logic [3:0]                         w_shift;
    logic [LIN_W-1:0]                   pix_idx;
    logic [LIN_W-1:0]                   byte_addr;
    logic [3:0]                         wpg;
    logic                               accept;
    logic                               last_word;

    // Linear byte address of the requested group
    always_comb begin
        case (row_limit)
            bitmap_pkg::rl_256: y_eff = {5'd0, req_y[7:0]};
            bitmap_pkg::rl_512: y_eff = {4'd0, req_y[8:0]};
            default:            y_eff = req_y;
        endcase
        case (image_width)
            bitmap_pkg::iw_256: begin
                x_eff   = {3'd0, req_x[7:4], 4'd0};
                w_shift = 4'd8;
            end
            bitmap_pkg::iw_512: begin
                x_eff   = {2'd0, req_x[8:4], 4'd0};
                w_shift = 4'd9;
            end
            bitmap_pkg::iw_1024: begin
                x_eff   = {1'd0, req_x[9:4], 4'd0};
                w_shift = 4'd10;
            end
            default: begin
                x_eff   = {req_x[10:4], 4'd0};
                w_shift = 4'd11;
            end
        endcase
        pix_idx = (LIN_W'(y_eff) << w_shift) + LIN_W'(x_eff);  // Pixel number in image
        case (color_mode)
            bitmap_pkg::cm_2bpp: byte_addr = pix_idx >> 2;
            bitmap_pkg::cm_4bpp: byte_addr = pix_idx >> 1;
            bitmap_pkg::cm_8bpp: byte_addr = pix_idx;
            default:             byte_addr = pix_idx << 1;
        endcase
    end

    assign wpg       = bitmap_pkg::words_per_group(color_mode);
    assign last_word = ({1'b0, word_idx} == wpg - 4'd1);
    assign req_ready = (state == st_idle) && !bank_full[fill_ptr];
    assign accept    = req_valid && req_ready;
    assign arvalid   = (state == st_addr);
    assign rready    = (state == st_data);

    assign lw.bank   = fill_ptr;
    assign lw.word   = word_idx;
    assign lw.data   = {<<8{rdata}};                  // Byte-reversed word
    assign lw.strobe = rready && rvalid;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            state          <= st_idle;
            word_idx       <= '0;
            fill_ptr       <= 1'b0;
            bank_full      <= 2'b00;
            bh.filled      <= 1'b0;
            bh.filled_bank <= 1'b0;
        end else begin
            bh.filled <= 1'b0;
            if (bh.freed) bank_full[bh.freed_bank] <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        word_idx <= '0;
                        state    <= st_addr;
                    end
                end
                st_addr: if (arready) state <= st_data;
                st_data: begin
                    if (rvalid && last_word) begin
                        state               <= st_idle;
                        bank_full[fill_ptr] <= 1'b1;
                        bh.filled           <= 1'b1;
                        bh.filled_bank      <= fill_ptr;
                        fill_ptr            <= ~fill_ptr;
                    end else if (rvalid) begin
                        word_idx <= word_idx + 1'b1;
                        state    <= st_addr;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Address held until arready, next word follows at plus 4
    always_ff @(posedge CLK) begin
        if (accept) araddr <= byte_addr[ADDR_W-1:0];
        else if (lw.strobe) araddr <= araddr + ADDR_W'(4);
    end

endmodule

// File: source/line_buffer.sv
module line_buffer (
    input  logic            CLK,
    line_write_if.buffer    lw,
    bank_handoff_if.storage bh
);
    localparam int DEPTH = 2 * bitmap_pkg::BANK_WORDS;

    // Bank number is the top address bit
    logic [bitmap_pkg::WORD_W-1:0] mem [DEPTH];

    always_ff @(posedge CLK) begin
        if (lw.strobe) begin
            mem[{lw.bank, lw.word}] <= lw.data;
        end
        bh.rd_data <= mem[{bh.rd_bank, bh.rd_word}];  // Registered read
    end

endmodule

// File: source/pixel_unpack.sv
module pixel_unpack (
    input  logic                           CLK,
    input  logic                           RESET_n,
    input  bitmap_pkg::color_mode_e        color_mode,
    input  logic                           stall,
    output logic [bitmap_pkg::PIXEL_W-1:0] pix_raw,
    output logic                           raw_valid,
    bank_handoff_if.consumer               bh
);
    logic [1:0] q_count;
    logic [1:0] q_bank;         // Entry 0 is the oldest filled bank
    logic [3:0] pos;            // Position being read
    logic [3:0] pos_d;          // Position whose word is on rd_data
    logic       bank_d;
    logic [3:0] wpg;
    logic       active;
    logic       push;
    logic       pop;

    // Word holding a pixel position, pos * words / 16
    function automatic logic [bitmap_pkg::BANK_ADDR_W-1:0] word_of(
        input logic [3:0] p,
        input logic [3:0] words
    );
        logic [7:0] prod;
        prod = p * words;
        return prod[6:4];
    endfunction

    assign wpg    = bitmap_pkg::words_per_group(color_mode);
    assign active = (q_count != 2'd0);
    assign push   = bh.filled;
    assign pop    = active && !stall && (pos == 4'd15);

    // Re-read the held word while stalled
    assign bh.rd_bank    = stall ? bank_d : q_bank[0];
    assign bh.rd_word    = stall ? word_of(pos_d, wpg) : word_of(pos, wpg);
    assign bh.freed      = !stall && raw_valid && (pos_d == 4'd15);  // Last pixel leaves
    assign bh.freed_bank = bank_d;

    // Pixels sit MSB first in each word
    always_comb begin
        pix_raw = '0;
        case (color_mode)
            bitmap_pkg::cm_2bpp:
                pix_raw[1:0] = bh.rd_data[5'd31 - {pos_d, 1'b0} -: 2];
            bitmap_pkg::cm_4bpp:
                pix_raw[3:0] = bh.rd_data[5'd31 - {pos_d[2:0], 2'b0} -: 4];
            bitmap_pkg::cm_8bpp:
                pix_raw[7:0] = bh.rd_data[5'd31 - {pos_d[1:0], 3'b0} -: 8];
            default:
                pix_raw = bh.rd_data[5'd31 - {pos_d[0], 4'b0} -: 16];
        endcase
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            pos       <= 4'd0;
            pos_d     <= 4'd0;
            bank_d    <= 1'b0;
            raw_valid <= 1'b0;
            q_count   <= 2'd0;
            q_bank    <= 2'b00;
        end else begin
            if (!stall) begin
                raw_valid <= active;
                pos_d     <= pos;
                bank_d    <= q_bank[0];
                if (active) pos <= pos + 4'd1;  // Wraps to 0 after 15
            end
            case ({push, pop})
                2'b10: begin
                    if (q_count == 2'd0) q_bank[0] <= bh.filled_bank;
                    else q_bank[1] <= bh.filled_bank;
                    q_count <= q_count + 2'd1;
                end
                2'b01: begin
                    q_bank[0] <= q_bank[1];
                    q_count   <= q_count - 2'd1;
                end
                2'b11: begin
                    if (q_count == 2'd1) begin
                        q_bank[0] <= bh.filled_bank;
                    end else begin
                        q_bank[0] <= q_bank[1];
                        q_bank[1] <= bh.filled_bank;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// File: source/pixel_decode.sv
module pixel_decode (
    input  logic                           CLK,
    input  logic                           RESET_n,
    input  bitmap_pkg::color_mode_e        color_mode,
    input  bitmap_pkg::palette_mode_e      palette_mode,
    input  logic [3:0]                     palette_offset,
    input  logic [bitmap_pkg::PIXEL_W-1:0] pix_raw,
    input  logic                           raw_valid,
    input  logic                           pix_ready,
    output logic                           stall,
    output logic                           pix_valid,
    output logic [5:0]                     pix_index,
    output logic [bitmap_pkg::PIXEL_W-1:0] pix_color,
    output logic                           pix_low_priority
);
    logic [5:0]                     index_next;
    logic [bitmap_pkg::PIXEL_W-1:0] color_next;
    logic                           low_next;

    always_comb begin
        index_next = 6'd0;
        color_next = '0;
        low_next   = 1'b0;
        case (color_mode)
            bitmap_pkg::cm_2bpp: begin
                index_next = {palette_offset, pix_raw[1:0]};
                low_next   = (pix_raw[1:0] == 2'd0);
            end
            bitmap_pkg::cm_4bpp: begin
                index_next = {palette_offset[3:2], pix_raw[3:0]};
                low_next   = (pix_raw[3:0] == 4'd0);
            end
            bitmap_pkg::cm_8bpp: begin
                if (palette_mode == bitmap_pkg::pm_direct) begin
                    color_next = pix_raw;               // Upper byte already zero
                    low_next   = 1'b1;
                end else begin
                    index_next = pix_raw[5:0];
                    low_next   = (pix_raw[5:0] == 6'd0);
                end
            end
            default: color_next = pix_raw;          // 16 bpp direct color
        endcase
    end

    assign stall = pix_valid && !pix_ready;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) pix_valid <= 1'b0;
        else if (!stall) pix_valid <= raw_valid;
    end

    always_ff @(posedge CLK) begin
        if (!stall && raw_valid) begin
            pix_index        <= index_next;
            pix_color        <= color_next;
            pix_low_priority <= low_next;
        end
    end

endmodule

// File: source/bitmap_layer.sv
module bitmap_layer #(
    parameter int ADDR_W = bitmap_pkg::VRAM_ADDR_W
) (
    input  logic                           CLK,
    input  logic                           RESET_n,

    input  bitmap_pkg::color_mode_e        color_mode,
    input  bitmap_pkg::image_width_e       image_width,
    input  bitmap_pkg::row_limit_e         row_limit,
    input  bitmap_pkg::palette_mode_e      palette_mode,
    input  logic [3:0]                     palette_offset,

    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic [10:0]                    req_x,
    input  logic [12:0]                    req_y,

    output logic [ADDR_W-1:0]              araddr,
    output logic                           arvalid,
    input  logic                           arready,
    input  logic [bitmap_pkg::WORD_W-1:0]  rdata,
    input  logic                           rvalid,
    output logic                           rready,

    output logic                           pix_valid,
    input  logic                           pix_ready,
    output logic [5:0]                     pix_index,
    output logic [bitmap_pkg::PIXEL_W-1:0] pix_color,
    output logic                           pix_low_priority
);
    logic                           stall;
    logic                           raw_valid;
    logic [bitmap_pkg::PIXEL_W-1:0] pix_raw;

    line_write_if   lw ();
    bank_handoff_if bh ();

    bitmap_fetch #(
        .ADDR_W (ADDR_W)
    ) u_fetch (
        .CLK,
        .RESET_n,
        .color_mode,
        .image_width,
        .row_limit,
        .req_valid,
        .req_ready,
        .req_x,
        .req_y,
        .araddr,
        .arvalid,
        .arready,
        .rdata,
        .rvalid,
        .rready,
        .lw     (lw.writer),
        .bh     (bh.producer)
    );

    line_buffer u_buffer (
        .CLK,
        .lw     (lw.buffer),
        .bh     (bh.storage)
    );

    pixel_unpack u_unpack (
        .CLK,
        .RESET_n,
        .color_mode,
        .stall,
        .pix_raw,
        .raw_valid,
        .bh     (bh.consumer)
    );

    pixel_decode u_decode (
        .CLK,
        .RESET_n,
        .color_mode,
        .palette_mode,
        .palette_offset,
        .pix_raw,
        .raw_valid,
        .pix_ready,
        .stall,
        .pix_valid,
        .pix_index,
        .pix_color,
        .pix_low_priority
    );

endmodule

// File: test/tb_bitmap_layer.sv
module tb_bitmap_layer;
    localparam int ADDR_W      = bitmap_pkg::VRAM_ADDR_W;
    localparam int PIXEL_W     = bitmap_pkg::PIXEL_W;
    localparam int BATCHES     = 25;
    localparam int BATCH_REQS  = 8;
    localparam int CYCLE_LIMIT = BATCHES * BATCH_REQS * 400;

    logic CLK;
    logic RESET_n;
    bitmap_pkg::color_mode_e    color_mode;
    bitmap_pkg::image_width_e   image_width;
    bitmap_pkg::row_limit_e     row_limit;
    bitmap_pkg::palette_mode_e  palette_mode;
    logic [3:0]                 palette_offset;
    logic                       req_valid;
    logic                       req_ready;
    logic [10:0]                req_x;
    logic [12:0]                req_y;
    logic [ADDR_W-1:0]          araddr;
    logic                       arvalid;
    logic                       arready;
    logic [31:0]                rdata;
    logic                       rvalid;
    logic                       rready;
    logic                       pix_valid;
    logic                       pix_ready;
    logic [5:0]                 pix_index;
    logic [PIXEL_W-1:0]         pix_color;
    logic                       pix_low_priority;

    logic [31:0]        seed = 32'd47;
    int                 errors, requests, pixels, overlaps, cycles;
    logic [ADDR_W-1:0]  exp_addr[$];      // Model queues, in request order
    logic [5:0]         exp_index[$];
    logic [PIXEL_W-1:0] exp_color[$];
    logic               exp_low[$];

    bitmap_layer #(.ADDR_W(ADDR_W)) uut (.*);

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {16'd0, seed[31:16]};     // Upper bits of the LCG
    endfunction

    // Video memory contents, a hash of the byte address
    function automatic logic [31:0] mem_word(input logic [ADDR_W-1:0] addr);
        logic [31:0] h;
        h = 32'(addr) * 32'h9E37_79B1;
        return h ^ (h >> 16);
    endfunction

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [ADDR_W-1:0] group_addr(input logic [10:0] x, input logic [12:0] y);
        longint width;
        longint row;
        longint col;
        longint bpp;
        width = longint'(256) << image_width;
        row   = longint'(y);
        if (row_limit == bitmap_pkg::rl_256) row = row % 256;
        else if (row_limit == bitmap_pkg::rl_512) row = row % 512;
        col = (longint'(x) % width) / 16 * 16;   // Low 4 bits of x ignored
        bpp = longint'(2) << color_mode;
        return ADDR_W'((row * width + col) * bpp / 8);
    endfunction

    // Queue the reads and the 16 decoded pixels of one request
    task automatic push_expected(input logic [10:0] x, input logic [12:0] y);
        logic [ADDR_W-1:0]  base;
        logic [31:0]        word;
        logic [15:0]        v;
        logic [5:0]         index;
        logic [PIXEL_W-1:0] color;
        logic               low;
        int bpp, bit_pos, k, p;
        bpp  = 2 << color_mode;
        base = group_addr(x, y);
        for (k = 0; k < bpp / 2; k++) exp_addr.push_back(base + ADDR_W'(4 * k));
        for (p = 0; p < 16; p++) begin
            bit_pos = p * bpp;
            word    = swap_bytes(mem_word(base + ADDR_W'(4 * (bit_pos / 32))));
            v       = 16'((word >> (32 - bit_pos % 32 - bpp)) & ((32'd1 << bpp) - 32'd1));
            index   = 6'd0;
            color   = '0;
            low     = 1'b0;
            case (color_mode)
                bitmap_pkg::cm_2bpp: begin
                    index = {palette_offset, v[1:0]};
                    low   = (v[1:0] == 2'd0);
                end
                bitmap_pkg::cm_4bpp: begin
                    index = {palette_offset[3:2], v[3:0]};
                    low   = (v[3:0] == 4'd0);
                end
                bitmap_pkg::cm_8bpp: begin
                    if (palette_mode == bitmap_pkg::pm_direct) begin
                        color = v;
                        low   = 1'b1;
                    end else begin
                        index = v[5:0];
                        low   = (v[5:0] == 6'd0);
                    end
                end
                default: color = v;
            endcase
            exp_index.push_back(index);
            exp_color.push_back(color);
            exp_low.push_back(low);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                              input logic [ADDR_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_pixel(input string name, input logic [5:0] exp_idx,
                               input logic [PIXEL_W-1:0] exp_col, input logic exp_lo,
                               input logic [5:0] act_idx, input logic [PIXEL_W-1:0] act_col,
                               input logic act_lo);
        if ({act_idx, act_col, act_lo} !== {exp_idx, exp_col, exp_lo}) begin
            errors++;
            $display("error %s: expected index %h color %h low %b actual index %h color %h low %b",
                     name, exp_idx, exp_col, exp_lo, act_idx, act_col, act_lo);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic send_request(input logic [10:0] x, input logic [12:0] y);
        req_valid = 1'b1;
        req_x     = x;
        req_y     = y;
        while (!req_ready) @(negedge CLK);
        if (exp_index.size() > 1) overlaps++;  // An earlier group still waits in a bank
        push_expected(x, y);
        requests++;
        @(negedge CLK);
    endtask

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the pixel stream did not finish", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // AXI4-Lite read responder with random delays
    initial begin
        logic              rd_busy;
        int                rd_wait;
        logic [ADDR_W-1:0] rd_addr;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rd_busy = 1'b0;
        rd_wait = 0;
        rd_addr = '0;
        forever begin
            @(negedge CLK);
            arready = 1'b0;
            if (rvalid) begin
                rvalid = 1'b0;                 // Taken at the last rising edge
            end else if (rd_busy && rd_wait > 0) begin
                rd_wait--;
            end else if (rd_busy) begin
                rdata   = mem_word(rd_addr);
                rvalid  = 1'b1;
                rd_busy = 1'b0;
                check_bit("rready", 1'b1, rready);  // Read still outstanding
            end else if (arvalid && next_rand() % 3 != 0) begin
                arready = 1'b1;
                rd_addr = araddr;
                rd_busy = 1'b1;
                rd_wait = int'(next_rand() % 4);
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("A read was issued with no request pending");
                end else begin
                    check_addr("araddr", exp_addr.pop_front(), araddr);
                end
            end
        end
    end

    // Pixel sink with random back-pressure
    initial begin
        pix_ready = 1'b0;
        forever begin
            @(negedge CLK);
            pix_ready = (next_rand() % 3 != 0);
            if (pix_valid && pix_ready) begin
                pixels++;
                if (exp_index.size() == 0) begin
                    errors++;
                    $display("A pixel arrived with no request pending");
                end else begin
                    check_pixel($sformatf("pixel %0d", pixels), exp_index.pop_front(),
                                exp_color.pop_front(), exp_low.pop_front(),
                                pix_index, pix_color, pix_low_priority);
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        int b, n;
        RESET_n        = 1'b0;
        req_valid      = 1'b0;
        req_x          = '0;
        req_y          = '0;
        color_mode     = bitmap_pkg::cm_2bpp;
        image_width    = bitmap_pkg::iw_256;
        row_limit      = bitmap_pkg::rl_256;
        palette_mode   = bitmap_pkg::pm_palette;
        palette_offset = 4'd0;
        repeat (16) @(negedge CLK);
        RESET_n = 1'b1;
        @(negedge CLK);
        check_bit("reset arvalid", 1'b0, arvalid);
        check_bit("reset pix_valid", 1'b0, pix_valid);
        check_bit("reset req_ready", 1'b1, req_ready);

        for (b = 0; b < BATCHES; b++) begin
            r              = next_rand();
            color_mode     = bitmap_pkg::color_mode_e'(b[1:0]);   // All four modes in turn
            palette_mode   = bitmap_pkg::palette_mode_e'(b[2]);
            image_width    = bitmap_pkg::image_width_e'(r[1:0]);
            row_limit      = (r[3:2] == 2'd3) ? bitmap_pkg::rl_none
                                              : bitmap_pkg::row_limit_e'(r[3:2]);
            palette_offset = r[7:4];
            for (n = 0; n < BATCH_REQS; n++) begin
                send_request(11'(next_rand()), 13'(next_rand()));
            end
            req_valid = 1'b0;
            while (exp_index.size() != 0) @(negedge CLK);  // Modes stay put until drained
        end
        repeat (20) @(negedge CLK);

        if (overlaps == 0) begin
            errors++;
            $display("No request was accepted while earlier pixels were pending");
        end
        if (pixels != requests * 16 || exp_addr.size() != 0) begin
            errors++;
            $display("Pixel or read count does not match 16 pixels per request");
        end
        $display("Requests %0d, pixels %0d, overlapped %0d, errors %0d",
                 requests, pixels, overlaps, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
source/bitmap_pkg.sv
source/bitmap_if.sv
source/bitmap_fetch.sv
source/line_buffer.sv
source/pixel_unpack.sv
source/pixel_decode.sv
source/bitmap_layer.sv
test/tb_bitmap_layer.sv

// File: run.sh
#!/bin/sh
# Build the bitmap layer testbench with Verilator, run it, and check the log

verilator --binary --timing -Wno-fatal --top-module tb_bitmap_layer -f verilog.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
exit 1
